// File: rtl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// instruction queue entries
// upstream holds this many credits after reset
`define QUEUE_DEPTH 4

// results the core may send before the first credit comes back
`define OUT_CREDITS 2

// datapath width
`define XLEN 32

`endif

// File: rtl/CorePkg.sv
package CorePkg;

    typedef logic [4:0] RegAddr;

    // opcode and funct encodings, MIPS32
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpAndi    = 6'h0c;
    localparam logic [5:0] OpOri     = 6'h0d;
    localparam logic [5:0] OpLui     = 6'h0f;
    localparam logic [5:0] FnAddu    = 6'h21;
    localparam logic [5:0] FnSubu    = 6'h23;
    localparam logic [5:0] FnAnd     = 6'h24;
    localparam logic [5:0] FnOr      = 6'h25;
    localparam logic [5:0] FnXor     = 6'h26;
    localparam logic [5:0] FnSlt     = 6'h2a;

    typedef struct packed {
        logic [5:0]  op;
        RegAddr      rs;
        RegAddr      rt;
        RegAddr      rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } RFormat;

    typedef struct packed {
        logic [5:0]  op;
        RegAddr      rs;
        RegAddr      rt;
        logic [15:0] imm;
    } IFormat;

    // same word, register or immediate view
    typedef union packed {
        RFormat rType;
        IFormat iType;
    } InstrWord;

    typedef struct packed {
        logic [31:0] pc;
        InstrWord    instr;
    } InstrPacket;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluXor   = 3'd4,
        aluSlt   = 3'd5,
        aluPassB = 3'd6
    } AluOp;

    typedef struct packed {
        AluOp   aluOp;
        logic   useImm;     // opB from immediate
        logic   zeroExt;
        logic   luiShift;
        logic   regWrite;
        logic   illegal;
        RegAddr dst;
    } CtrlWord;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        CtrlWord     ctrl;
        logic [31:0] opA;
        logic [31:0] opB;
    } IdExBundle;

    // forwarding source, execute or write-back
    typedef struct packed {
        logic        valid;
        logic        regWrite;
        RegAddr      dst;
        logic [31:0] value;
    } Bypass;

    typedef struct packed {
        logic [31:0] pc;
        RegAddr      dst;
        logic [31:0] value;
        logic        illegal;
    } ResultRec;

endpackage

// File: rtl/InstrQueue.sv
`timescale 1ns/1ns
`include "core_params.svh"

module InstrQueue import CorePkg::*; #(
    parameter int Depth = `QUEUE_DEPTH
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       instrValid,
    input  InstrPacket instrIn,
    input  logic       hold,
    output logic       headValid,
    output InstrPacket head,
    output logic       instrCredit
);
    localparam int PtrW = $clog2(Depth);

    InstrPacket        mem [Depth];
    logic [PtrW-1:0]   rdPtr;
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW:0]     count;
    logic              pop;

    assign headValid = (count != '0);
    assign head      = mem[rdPtr];      // head read without a register
    assign pop       = headValid && !hold;

    // upstream spends a credit per push, so a push never finds the queue full
    always_ff @(posedge clk) begin
        if (instrValid) begin
            mem[wrPtr] <= instrIn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdPtr       <= '0;
            wrPtr       <= '0;
            count       <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count       <= count + (PtrW + 1)'(instrValid) - (PtrW + 1)'(pop);
            instrCredit <= pop;   // slot freed, credit back one cycle later
        end
    end

endmodule

// File: rtl/RegFile.sv
`timescale 1ns/1ns

module RegFile import CorePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  RegAddr      rs,
    input  RegAddr      rt,
    output logic [31:0] busA,
    output logic [31:0] busB,
    input  logic        wrEn,
    input  RegAddr      wrAddr,
    input  logic [31:0] wrData
);
    logic [31:0] regs [1:31];   // r0 has no storage

    // same-cycle write is not visible here, decode forwards it
    assign busA = (rs == '0) ? '0 : regs[rs];
    assign busB = (rt == '0) ? '0 : regs[rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// File: rtl/DecodeStage.sv
`timescale 1ns/1ns

module DecodeStage import CorePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       headValid,
    input  InstrPacket head,
    input  logic       hold,
    input  Bypass      exBypass,
    input  Bypass      wbBypass,
    output IdExBundle  idEx
);
    InstrWord    instr;
    CtrlWord     ctrl;
    logic [31:0] imm32;
    logic [31:0] busA;
    logic [31:0] busB;
    logic [31:0] opA;
    logic [31:0] rtValue;
    logic [31:0] opB;
    logic        rfWrite;

    // newest value wins, r0 never forwarded
    function automatic logic [31:0] pickOperand(input RegAddr src, input logic [31:0] rfValue,
                                                input Bypass ex, input Bypass wb);
        if (src != '0 && ex.valid && ex.regWrite && ex.dst == src) begin
            return ex.value;
        end
        if (src != '0 && wb.valid && wb.regWrite && wb.dst == src) begin
            return wb.value;
        end
        return rfValue;
    endfunction

    assign instr   = head.instr;
    assign rfWrite = wbBypass.valid && wbBypass.regWrite && !hold;   // only on retire

    RegFile uRegFile (
        .clk     (clk),
        .reset   (reset),
        .rs      (instr.rType.rs),
        .rt      (instr.rType.rt),
        .busA    (busA),
        .busB    (busB),
        .wrEn    (rfWrite),
        .wrAddr  (wbBypass.dst),
        .wrData  (wbBypass.value)
    );

    always_comb begin
        ctrl         = '0;
        ctrl.illegal = 1'b1;    // anything unmatched retires illegal
        case (instr.iType.op)
            OpSpecial: begin
                ctrl.illegal  = 1'b0;
                ctrl.regWrite = 1'b1;
                ctrl.dst      = instr.rType.rd;
                case (instr.rType.funct)
                    FnAddu:  ctrl.aluOp = aluAdd;
                    FnSubu:  ctrl.aluOp = aluSub;
                    FnAnd:   ctrl.aluOp = aluAnd;
                    FnOr:    ctrl.aluOp = aluOr;
                    FnXor:   ctrl.aluOp = aluXor;
                    FnSlt:   ctrl.aluOp = aluSlt;
                    default: begin
                        ctrl         = '0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            OpAddiu: begin
                ctrl.aluOp = aluAdd;
                ctrl.useImm = 1'b1;
            end
            OpAndi: begin
                ctrl.aluOp   = aluAnd;
                ctrl.useImm  = 1'b1;
                ctrl.zeroExt = 1'b1;
            end
            OpOri: begin
                ctrl.aluOp   = aluOr;
                ctrl.useImm  = 1'b1;
                ctrl.zeroExt = 1'b1;
            end
            OpLui: begin
                ctrl.aluOp    = aluPassB;
                ctrl.useImm   = 1'b1;
                ctrl.luiShift = 1'b1;
            end
            default: ;
        endcase
        if (ctrl.useImm) begin   // all I-type ops write rt
            ctrl.illegal  = 1'b0;
            ctrl.regWrite = 1'b1;
            ctrl.dst      = instr.iType.rt;
        end
    end

    always_comb begin
        if (ctrl.luiShift) begin
            imm32 = {instr.iType.imm, 16'h0000};
        end else if (ctrl.zeroExt) begin
            imm32 = {16'h0000, instr.iType.imm};
        end else begin
            imm32 = {{16{instr.iType.imm[15]}}, instr.iType.imm};
        end
    end

    assign opA     = pickOperand(instr.rType.rs, busA, exBypass, wbBypass);
    assign rtValue = pickOperand(instr.rType.rt, busB, exBypass, wbBypass);
    assign opB     = ctrl.useImm ? imm32 : rtValue;

    always_ff @(posedge clk) begin
        if (reset) begin
            idEx <= '0;
        end else if (!hold) begin
            idEx.valid <= headValid;   // empty queue gives a bubble
            idEx.pc    <= head.pc;
            idEx.ctrl  <= ctrl;
            idEx.opA   <= opA;
            idEx.opB   <= opB;
        end
    end

endmodule

// File: rtl/ExecuteStage.sv
`timescale 1ns/1ns
`include "core_params.svh"

module ExecuteStage import CorePkg::*; #(
    parameter int Credits = `OUT_CREDITS
) (
    input  logic      clk,
    input  logic      reset,
    input  IdExBundle idEx,
    input  logic      resultCredit,
    output Bypass     exBypass,
    output Bypass     wbBypass,
    output logic      hold,
    output logic      resultValid,
    output ResultRec  result
);
    localparam int CreditW = $clog2(Credits + 1);

    logic [`XLEN-1:0]   opA;
    logic [`XLEN-1:0]   opB;
    logic [`XLEN-1:0]   aluResult;
    logic               wbValid;
    logic               wbRegWrite;
    ResultRec           wbRec;
    logic [CreditW-1:0] credits;
    logic               retire;

    assign opA = idEx.opA;
    assign opB = idEx.opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:   aluResult = opA + opB;   // wraps
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluXor:   aluResult = opA ^ opB;
            aluSlt:   aluResult = ($signed(opA) < $signed(opB)) ? `XLEN'd1 : `XLEN'd0;
            aluPassB: aluResult = opB;         // LUI
            default:  aluResult = '0;
        endcase
    end

    assign exBypass.valid    = idEx.valid;
    assign exBypass.regWrite = idEx.ctrl.regWrite;
    assign exBypass.dst      = idEx.ctrl.dst;
    assign exBypass.value    = aluResult;

    assign wbBypass.valid    = wbValid;
    assign wbBypass.regWrite = wbRegWrite;
    assign wbBypass.dst      = wbRec.dst;
    assign wbBypass.value    = wbRec.value;

    // stall the whole pipe while a finished result has nowhere to go
    assign hold        = wbValid && (credits == '0);
    assign retire      = wbValid && !hold;
    assign resultValid = retire;
    assign result      = wbRec;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbRec      <= '0;
        end else if (!hold) begin
            wbValid       <= idEx.valid;
            wbRegWrite    <= idEx.ctrl.regWrite;
            wbRec.pc      <= idEx.pc;
            wbRec.dst     <= idEx.ctrl.dst;
            wbRec.value   <= idEx.ctrl.illegal ? '0 : aluResult;   // illegal reports zero
            wbRec.illegal <= idEx.ctrl.illegal;
        end
    end

    // downstream never returns more than it was given
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CreditW'(Credits);
        end else begin
            credits <= credits + CreditW'(resultCredit) - CreditW'(retire);
        end
    end

endmodule

// File: rtl/IntCore.sv
`timescale 1ns/1ns
`include "core_params.svh"

module IntCore import CorePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instrValid,
    input  InstrPacket instrIn,
    output logic       instrCredit,
    output logic       resultValid,
    output ResultRec   result,
    input  logic       resultCredit
);
    logic       headValid;
    InstrPacket head;
    logic       hold;       // global stall from the result port
    IdExBundle  idEx;
    Bypass      exBypass;
    Bypass      wbBypass;

    InstrQueue #(.Depth(`QUEUE_DEPTH)) uInstrQueue (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instrIn      (instrIn),
        .hold         (hold),
        .headValid    (headValid),
        .head         (head),
        .instrCredit  (instrCredit)
    );

    DecodeStage uDecodeStage (
        .clk          (clk),
        .reset        (reset),
        .headValid    (headValid),
        .head         (head),
        .hold         (hold),
        .exBypass     (exBypass),
        .wbBypass     (wbBypass),
        .idEx         (idEx)
    );

    ExecuteStage #(.Credits(`OUT_CREDITS)) uExecuteStage (
        .clk          (clk),
        .reset        (reset),
        .idEx         (idEx),
        .resultCredit (resultCredit),
        .exBypass     (exBypass),
        .wbBypass     (wbBypass),
        .hold         (hold),
        .resultValid  (resultValid),
        .result       (result)
    );

endmodule

// File: testbench/resultChecker.sv
`timescale 1ns/1ns
`include "core_params.svh"

module resultChecker import CorePkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       instrValid,
    input  InstrPacket instrIn,
    input  logic       instrCredit,
    input  logic       resultValid,
    input  ResultRec   result,
    input  logic       resultCredit,
    input  logic       endOfTest,
    output int         mismatchCount,
    output int         protocolCount
);
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic        isolated;      // idle pipe and a free output credit at acceptance
        int          acceptCycle;
    } Pending;

    Pending      expectQ [$];
    Pending      entry;
    ResultRec    expected;
    logic [31:0] model [32];        // architectural registers as the program sees them
    int          cycle;
    int          accepted;
    int          creditPulses;
    int          results;
    int          creditsReturned;
    int          latencyChecks;
    logic        finalDone;

    // MIPS semantics for the supported subset, illegal retires as zero to r0
    function automatic ResultRec computeExpected(input logic [31:0] pc, input logic [31:0] word,
                                                 input logic [31:0] rsVal,
                                                 input logic [31:0] rtVal);
        ResultRec    rec;
        logic [15:0] imm;
        rec    = '0;
        rec.pc = pc;
        imm    = word[15:0];
        case (word[31:26])
            6'h00: begin
                rec.dst = word[15:11];
                case (word[5:0])
                    6'h21:   rec.value = rsVal + rtVal;
                    6'h23:   rec.value = rsVal - rtVal;
                    6'h24:   rec.value = rsVal & rtVal;
                    6'h25:   rec.value = rsVal | rtVal;
                    6'h26:   rec.value = rsVal ^ rtVal;
                    6'h2a:   rec.value = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
                    default: begin
                        rec.dst     = '0;
                        rec.illegal = 1'b1;
                    end
                endcase
            end
            6'h09: begin
                rec.dst   = word[20:16];
                rec.value = rsVal + {{16{imm[15]}}, imm};   // addiu sign-extends
            end
            6'h0c: begin
                rec.dst   = word[20:16];
                rec.value = rsVal & {16'h0000, imm};
            end
            6'h0d: begin
                rec.dst   = word[20:16];
                rec.value = rsVal | {16'h0000, imm};
            end
            6'h0f: begin
                rec.dst   = word[20:16];
                rec.value = {imm, 16'h0000};
            end
            default: rec.illegal = 1'b1;
        endcase
        return rec;
    endfunction

    task checkResult();
        results++;
        if (results > `OUT_CREDITS + creditsReturned) begin
            protocolCount++;
            $display("protocol error at %0t: result %0d sent with only %0d output credits issued",
                     $time, results, `OUT_CREDITS + creditsReturned);
        end
        if (expectQ.size() == 0) begin
            protocolCount++;
            $display("protocol error at %0t: result retired with no instruction outstanding",
                     $time);
        end else begin
            entry    = expectQ.pop_front();
            expected = computeExpected(entry.pc, entry.word, model[entry.word[25:21]],
                                       model[entry.word[20:16]]);
            if (result !== expected) begin
                mismatchCount++;
                $display("mismatch at %0t: pc %h/%h dst %0d/%0d value %h/%h illegal %b/%b",
                         $time, result.pc, expected.pc, result.dst, expected.dst,
                         result.value, expected.value, result.illegal, expected.illegal);
            end
            if (!expected.illegal && expected.dst != 5'd0) begin
                model[expected.dst] = expected.value;
            end
            if (entry.isolated) begin
                latencyChecks++;
                if (cycle - entry.acceptCycle != 3) begin
                    mismatchCount++;
                    $display("mismatch at %0t: pc %h retired %0d cycles after acceptance, not 3",
                             $time, entry.pc, cycle - entry.acceptCycle);
                end
            end
        end
    endtask

    task acceptPacket();
        accepted++;
        if (accepted - creditPulses > `QUEUE_DEPTH) begin
            protocolCount++;
            $display("protocol error at %0t: %0d packets outstanding but only %0d input credits",
                     $time, accepted - creditPulses, `QUEUE_DEPTH);
        end
        entry.pc          = instrIn.pc;
        entry.word        = instrIn.instr;
        entry.isolated    = (expectQ.size() == 0)
                            && (`OUT_CREDITS + creditsReturned - results > 0);
        entry.acceptCycle = cycle;
        expectQ.push_back(entry);
    endtask

    task runFinalChecks();
        finalDone = 1'b1;
        if (expectQ.size() != 0) begin
            protocolCount++;
            $display("error: %0d instructions were accepted but never retired", expectQ.size());
        end
        if (creditPulses != accepted) begin
            protocolCount++;
            $display("error: %0d input credit pulses returned for %0d packets sent",
                     creditPulses, accepted);
        end
        if (latencyChecks == 0) begin
            protocolCount++;
            $display("error: no isolated packet was seen, so latency was never checked");
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            expectQ.delete();
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
            cycle           = 0;
            accepted        = 0;
            creditPulses    = 0;
            results         = 0;
            creditsReturned = 0;
            latencyChecks   = 0;
            mismatchCount   = 0;
            protocolCount   = 0;
            finalDone       = 1'b0;
        end else begin
            cycle++;
            if (resultValid) begin
                checkResult();
            end
            if (resultCredit) begin   // usable by the DUT from the next cycle on
                creditsReturned++;
            end
            if (instrCredit) begin
                creditPulses++;
                if (creditPulses > accepted) begin
                    protocolCount++;
                    $display("protocol error at %0t: input credit returned with no packet held",
                             $time);
                end
            end
            if (instrValid) begin
                acceptPacket();
            end
            if (endOfTest && !finalDone) begin
                runFinalChecks();
            end
        end
    end

endmodule

// File: testbench/tbIntCore.sv
`timescale 1ns/1ns
`include "core_params.svh"

module tbIntCore import CorePkg::*; ();
    localparam int PhaseAPackets   = 120;
    localparam int PhaseBCycles    = 30;
    localparam int IsolatedPackets = 10;
    localparam int MaxPackets      = PhaseAPackets + PhaseBCycles + IsolatedPackets;
    localparam int WatchdogCycles  = MaxPackets * 40 + 200;

    logic       clk;
    logic       reset;
    logic       instrValid;
    InstrPacket instrIn;
    logic       instrCredit;
    logic       resultValid;
    ResultRec   result;
    logic       resultCredit;
    logic       endOfTest;
    int         mismatchCount;
    int         protocolCount;

    int          seed;
    int          sent;
    int          creditsBack;       // instrCredit pulses seen
    int          resultsSeen;
    int          creditsReturned;
    logic        withhold;          // keep output credits back
    logic [31:0] pc;
    logic        sentOne;

    IntCore DUT (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instrIn      (instrIn),
        .instrCredit  (instrCredit),
        .resultValid  (resultValid),
        .result       (result),
        .resultCredit (resultCredit)
    );

    resultChecker uChecker (
        .clk           (clk),
        .reset         (reset),
        .instrValid    (instrValid),
        .instrIn       (instrIn),
        .instrCredit   (instrCredit),
        .resultValid   (resultValid),
        .result        (result),
        .resultCredit  (resultCredit),
        .endOfTest     (endOfTest),
        .mismatchCount (mismatchCount),
        .protocolCount (protocolCount)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            creditsBack <= 0;
            resultsSeen <= 0;
        end else begin
            if (instrCredit) creditsBack <= creditsBack + 1;
            if (resultValid) resultsSeen <= resultsSeen + 1;
        end
    end

    // registers 0..7 only, so dependences come often
    task makeInstr(output logic [31:0] word);
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        kind = {$random(seed)} % 12;
        rs   = 5'({$random(seed)} % 8);
        rt   = 5'({$random(seed)} % 8);
        rd   = 5'({$random(seed)} % 8);
        imm  = 16'($random(seed));
        case (kind)
            0:       word = {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1:       word = {6'h00, rs, rt, rd, 5'd0, 6'h23};
            2:       word = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            3:       word = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4:       word = {6'h00, rs, rt, rd, 5'd0, 6'h26};
            5:       word = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            6:       word = {6'h09, rs, rt, imm};
            7:       word = {6'h0c, rs, rt, imm};
            8:       word = {6'h0d, rs, rt, imm};
            9:       word = {6'h0f, 5'd0, rt, imm};
            10:      word = {6'h00, rs, rt, rd, 5'd0, 6'h07};   // srav is not supported
            default: word = {6'h23, rs, rt, imm};               // lw is not supported
        endcase
    endtask

    // one falling edge of stimulus with maybe a packet and maybe an output credit
    task stepCycle(input logic trySend, output logic sentNow);
        logic [31:0] word;
        @(negedge clk);
        instrValid   = 1'b0;
        resultCredit = 1'b0;
        sentNow      = 1'b0;
        if (trySend && (sent - creditsBack) < `QUEUE_DEPTH) begin
            makeInstr(word);
            instrIn    = {pc, word};
            instrValid = 1'b1;
            sent++;
            pc      = pc + 32'd4;
            sentNow = 1'b1;
        end
        if (!withhold && resultsSeen > creditsReturned && ({$random(seed)} % 3) == 0) begin
            resultCredit = 1'b1;
            creditsReturned++;
        end
    endtask

    initial begin
        seed            = 46;
        reset           = 1'b1;
        instrValid      = 1'b0;
        instrIn         = '0;
        resultCredit    = 1'b0;
        endOfTest       = 1'b0;
        withhold        = 1'b0;
        sent            = 0;
        creditsReturned = 0;
        pc              = 32'h0000_1000;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (sent < PhaseAPackets) begin
            stepCycle(({$random(seed)} % 4) != 0, sentOne);
        end

        // back-pressure fills the pipe until it stalls
        withhold = 1'b1;
        repeat (PhaseBCycles) stepCycle(1'b1, sentOne);
        repeat (20) stepCycle(1'b0, sentOne);
        withhold = 1'b0;

        // lone packets into an idle pipe for the latency check
        repeat (IsolatedPackets) begin
            while (resultsSeen != sent || creditsReturned != resultsSeen) begin
                stepCycle(1'b0, sentOne);
            end
            sentOne = 1'b0;
            while (!sentOne) begin
                stepCycle(1'b1, sentOne);
            end
        end

        // every instrCredit pulse comes before the last result retires
        while (resultsSeen != sent || creditsReturned != resultsSeen) begin
            stepCycle(1'b0, sentOne);
        end
        endOfTest = 1'b1;
        @(posedge clk);
        #1;
        $display("errors: %0d mismatches, %0d protocol, 0 timeout", mismatchCount, protocolCount);
        if (mismatchCount == 0 && protocolCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WatchdogCycles);
        $display("errors: %0d mismatches, %0d protocol, 1 timeout", mismatchCount, protocolCount);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: intCore.f
+incdir+rtl
rtl/CorePkg.sv
rtl/InstrQueue.sv
rtl/RegFile.sv
rtl/DecodeStage.sv
rtl/ExecuteStage.sv
rtl/IntCore.sv
testbench/resultChecker.sv
testbench/tbIntCore.sv

// File: runSim.sh
#!/bin/sh
verilator --binary --timing --top-module tbIntCore -f intCore.f \
    && ./obj_dir/VtbIntCore | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
    && echo "intCore simulation passed" \
    || { echo "intCore simulation failed"; exit 1; }
